//--- compile.f
+incdir+include
src/proc_pkg.sv
src/hazardDetector.sv
src/fetchInstruction.sv
src/decodeInstruction.sv
src/executeInstruction.sv
src/memoryReadWrite.sv
src/proc.sv
dv/proc_properties.sv
dv/proc_tb.sv

//--- dv/proc_input.hex
// First word is the test count. Each test: header {commits[15:8], err[0]},
// 16 program words, then one {register, value} word pair per expected commit
0006
// Test 1: ALU ops, dependent chains, r0 writes and a word after HALT
0A00
6205 6443 1650 28C8 3AD0 4C50 5EE0 627F
2408 6047 1600 D000 6801 D000 D000 D000
0001 0005  0002 0008  0003 000D  0004 0008  0005 0008
0006 000D  0007 0005  0001 0004  0002 FFFC  0003 0000
// Test 2: stores and loads, including an untouched address
0700
6219 640A 8283 7683 7814 1AD8 8A1F 7C1F
827F 7E8E D000 D000 D000 D000 D000 D000
0001 0019  0002 000A  0003 0019  0004 0000  0005 0032  0006 0032  0007 0019
// Test 3: BEQZ and BNEZ, taken and not taken
0300
6202 9043 6407 A042 6601 6801 9002 6A01
6C01 A001 6681 D000 D000 D000 D000 D000
0001 0002  0002 0007  0003 0008
// Test 4: JAL link into r7 and forward J
0400
6201 C002 6405 6605 19C8 B003 6A05 6C05
6406 6B02 B001 6C01 D000 D000 D000 D000
0001 0001  0007 0002  0004 0003  0005 0005
// Test 5: illegal opcode raises err and the program runs on to HALT
0201
6203 E000 6441 D000 D000 D000 D000 D000
D000 D000 D000 D000 D000 D000 D000 D000
0001 0003  0002 0004
// Test 6: backward BNEZ loop, r0 write, words after HALT
0800
6203 6482 627F A07D 1090 1610 D000 6801
6A01 D000 D000 D000 D000 D000 D000 D000
0001 0003  0002 0002  0001 0002  0002 0004
0001 0001  0002 0006  0001 0000  0003 0006

//--- dv/proc_properties.sv
// proc pipeline checks: sticky status flags, commit trace and redirect spacing
`timescale 1ns/1ps
`default_nettype none

module proc_properties import proc_pkg::*; (
  input wire logic   clk,
  input wire logic   rst,
  input wire logic   wbValid,
  input wire regIdxT wbReg,
  input wire logic   halted,
  input wire logic   err,
  input wire logic   redirect
);

  // Status flags only clear through reset
  haltedSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else $error("halted dropped without a reset");

  errSticky: assert property (@(posedge clk) disable iff (rst) err |=> err)
    else $error("err dropped without a reset");

  noZeroCommit: assert property (@(posedge clk) disable iff (rst) wbValid |-> wbReg != '0)
    else $error("commit reported for r0");

  noCommitAfterHalt: assert property (@(posedge clk) disable iff (rst) halted |-> !wbValid)
    else $error("commit seen while halted");

  // The flushed slot behind a redirect can never redirect again
  singleRedirect: assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect)
    else $error("redirect held for two cycles");

endmodule

`default_nettype wire

//--- dv/proc_tb.sv
// proc testbench: loads each program from the data file and checks its commit trace
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module proc_tb import proc_pkg::*; ();

  localparam int ClkPeriod     = 100;
  localparam int ResetCycles   = 16;
  localparam int ProgWords     = `PROC_IMEM_DEPTH;
  localparam int CyclesPerTest = 216;  // Reset and load plus the longest program
  localparam int DrainCycles   = 4;

  logic              clk = 1'b0;
  logic              rst;
  logic              imemWrEn;
  logic [ImemAw-1:0] imemAddr;
  dataT              imemData;
  logic              wbValid;
  regIdxT            wbReg;
  dataT              wbData;
  logic              halted;
  logic              err;

  dataT vec [0:511];  // Whole data file
  int   numTests;
  int   ptr;          // Next unread word in vec
  int   passCount;
  int   failCount;

  proc uut (
    .clk, .rst, .imemWrEn, .imemAddr, .imemData,
    .wbValid, .wbReg, .wbData, .halted, .err
  );

  bind proc proc_properties checks (
    .clk(clk), .rst(rst), .wbValid(wbValid), .wbReg(wbReg),
    .halted(halted), .err(err), .redirect(redirect)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Holds reset while the program goes in one word per cycle
  task automatic loadProgram(input int base);
    for (int i = 0; i < ResetCycles; i++) begin
      @(posedge clk);
      rst      <= 1'b1;
      imemWrEn <= (i < ProgWords);
      imemAddr <= ImemAw'(i);
      imemData <= vec[base + (i % ProgWords)];
    end
    @(posedge clk);
    rst      <= 1'b0;
    imemWrEn <= 1'b0;
  endtask

  task automatic runTest(input int testNum);
    int     expCount;
    logic   expErr;
    int     expBase;
    int     progBase;
    int     commits;
    int     errors;
    bit     done;
    regIdxT expReg;
    dataT   expVal;
    expCount = int'(vec[ptr][15:8]);
    expErr   = vec[ptr][0];
    progBase = ptr + 1;
    expBase  = progBase + ProgWords;
    ptr      = expBase + 2 * expCount;
    commits  = 0;
    errors   = 0;
    done     = 1'b0;
    loadProgram(progBase);
    while (!done) begin
      @(negedge clk);
      if (wbValid) begin
        if (commits >= expCount) begin
          $display("Test %0d: extra commit r%0d=%h at %0d ns, more than the %0d expected",
                   testNum, wbReg, wbData, $time, expCount);
          errors++;
        end else begin
          expReg = vec[expBase + 2 * commits][RegW-1:0];
          expVal = vec[expBase + 2 * commits + 1];
          assert (wbReg == expReg && wbData == expVal) else begin
            $display("MISMATCH at %0d ns: test %0d commit %0d wrote r%0d=%h, expected r%0d=%h",
                     $time, testNum, commits, wbReg, wbData, expReg, expVal);
            errors++;
          end
        end
        commits++;
      end
      if (halted || (err && !expErr)) done = 1'b1;
    end
    // Nothing may commit once halted
    if (halted) begin
      repeat (DrainCycles) begin
        @(negedge clk);
        if (wbValid) begin
          $display("Test %0d: r%0d was written after the processor halted", testNum, wbReg);
          errors++;
        end
      end
    end
    if (commits < expCount) begin
      $display("Test %0d: only %0d of %0d expected commits were seen",
               testNum, commits, expCount);
      errors++;
    end
    assert (err == expErr) else begin
      $display("MISMATCH at %0d ns: test %0d error flag ended at %0b, expected %0b",
               $time, testNum, err, expErr);
      errors++;
    end
    if (errors == 0) begin
      passCount++;
      $display("Test %0d passed with %0d commits", testNum, commits);
    end else begin
      failCount++;
      $display("Test %0d failed with %0d errors", testNum, errors);
    end
  endtask

  initial begin
    rst       = 1'b1;
    imemWrEn  = 1'b0;
    imemAddr  = '0;
    imemData  = '0;
    passCount = 0;
    failCount = 0;
    $readmemh("dv/proc_input.hex", vec);
    numTests = int'(vec[0]);
    ptr      = 1;
    if (numTests == 0) $display("No tests found in the data file");
    for (int t = 1; t <= numTests; t++) runTest(t);
    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && numTests > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog sized from the number of tests
  initial begin
    wait (numTests > 0);
    #(numTests * CyclesPerTest * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles per test", CyclesPerTest);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- include/proc_settings.svh
// proc sizing and encoding constants shared by the pipeline and its testbench
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// Datapath and instruction word width
`define PROC_DATA_W 16

`define PROC_NUM_REGS 8  // r0 reads as zero

// Words per loaded program, PC wraps at this depth
`define PROC_IMEM_DEPTH 16

// Word-addressed data memory
`define PROC_DMEM_DEPTH 256

// HALT encoding in instruction bits 15..12
`define PROC_OP_HALT 4'hD

`endif

//--- run_sim.sh
#!/bin/sh
# Build the proc testbench with Verilator, run it and look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module proc_tb -f compile.f \
  -Mdir obj_dir -o proc_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/proc_sim > sim.log 2>&1
cat sim.log
grep -qx '>>> PASS' sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

//--- src/decodeInstruction.sv
// proc decode stage: control decode, register file, immediates and the ID/EX register
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module decodeInstruction import proc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire ifIdT  ifId,
  input  wire logic  stall,
  input  wire logic  redirect,
  input  wire memWbT memWb,
  output idExT       idEx,
  output srcUseT     srcUse,
  output destT       idExDest,
  output logic       halting,
  output logic       err
);

  dataT   regs [`PROC_NUM_REGS];
  opcodeT op;
  regIdxT rdField, rsField, rtField, srcB, destRd;
  logic   usesRs, usesRt, writesReg, illegal;
  logic   moveOn;
  dataT   opA, opB, immExt;

  assign op      = opcodeT'(ifId.instr[15:12]);
  assign rdField = ifId.instr[11:9];
  assign rsField = ifId.instr[8:6];
  assign rtField = ifId.instr[5:3];
  assign srcB    = (op == opSt) ? rdField : rtField;  // ST reads its data from rd
  assign destRd  = (op == opJal) ? LinkReg : rdField;

  always_comb begin
    usesRs    = 1'b0;
    usesRt    = 1'b0;
    writesReg = 1'b0;
    illegal   = 1'b0;
    case (op)
      opNop, opHalt, opJ: illegal = 1'b0;
      opAdd, opSub, opAnd, opOr, opXor: begin
        usesRs    = 1'b1;
        usesRt    = 1'b1;
        writesReg = 1'b1;
      end
      opAddi, opLd: begin
        usesRs    = 1'b1;
        writesReg = 1'b1;
      end
      opSt: begin
        usesRs = 1'b1;
        usesRt = 1'b1;
      end
      opBeqz, opBnez: usesRs = 1'b1;
      opJal:          writesReg = 1'b1;
      default:        illegal = 1'b1;
    endcase
  end

  // J and JAL carry a 12-bit offset, everything else 6 bits
  assign immExt = (op == opJ || op == opJal) ?
                  {{(DataW-12){ifId.instr[11]}}, ifId.instr[11:0]} :
                  {{(DataW-6){ifId.instr[5]}}, ifId.instr[5:0]};

  // Write-through read so MEM/WB results are seen in the same cycle
  function automatic dataT readReg(input regIdxT idx);
    if (idx == '0) return '0;
    if (memWb.valid && memWb.regWrite && memWb.rd == idx) return memWb.data;
    return regs[idx];
  endfunction

  always_comb begin
    opA = readReg(rsField);
    opB = readReg(srcB);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `PROC_NUM_REGS; i++) regs[i] <= '0;
    end else if (memWb.valid && memWb.regWrite && memWb.rd != '0) begin
      regs[memWb.rd] <= memWb.data;
    end
  end

  assign srcUse = '{rs: rsField, rt: srcB,
                    usesRs: usesRs && ifId.valid, usesRt: usesRt && ifId.valid};

  // Instruction leaves decode this cycle
  assign moveOn = ifId.valid && !stall && !redirect && !halting;

  always_ff @(posedge clk) begin
    if (rst) begin
      idEx.valid <= 1'b0;
      halting    <= 1'b0;
      err        <= 1'b0;
    end else begin
      idEx.valid <= moveOn && !illegal;  // Illegal words go on as bubbles
      if (moveOn && illegal) err <= 1'b1;
      if (moveOn && op == opHalt) halting <= 1'b1;
    end
    idEx.op       <= op;
    idEx.rd       <= destRd;
    idEx.regWrite <= writesReg;
    idEx.a        <= opA;
    idEx.b        <= opB;
    idEx.imm      <= immExt;
    idEx.pc       <= ifId.pc;
  end

  assign idExDest = '{valid: idEx.valid, regWrite: idEx.regWrite, rd: idEx.rd};

endmodule

`default_nettype wire

//--- src/executeInstruction.sv
// proc execute stage: ALU, branch and jump resolution, and the EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module executeInstruction import proc_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  wire idExT idEx,
  output exMemT     exMem,
  output destT      exMemDest,
  output logic      redirect,
  output dataT      redirectPc
);

  dataT aluOut;
  dataT linkPc;
  logic taken;

  assign linkPc = idEx.pc + 1'b1;

  always_comb begin
    case (idEx.op)
      opAdd:              aluOut = idEx.a + idEx.b;
      opSub:              aluOut = idEx.a - idEx.b;
      opAnd:              aluOut = idEx.a & idEx.b;
      opOr:               aluOut = idEx.a | idEx.b;
      opXor:              aluOut = idEx.a ^ idEx.b;
      opAddi, opLd, opSt: aluOut = idEx.a + idEx.imm;  // Also the memory address
      opJal:              aluOut = linkPc;
      default:            aluOut = '0;
    endcase
  end

  // Branches test operand a only
  always_comb begin
    case (idEx.op)
      opBeqz:     taken = (idEx.a == '0);
      opBnez:     taken = (idEx.a != '0);
      opJ, opJal: taken = 1'b1;
      default:    taken = 1'b0;
    endcase
  end

  // Predict not taken, so any taken control transfer redirects
  assign redirect   = idEx.valid && taken;
  assign redirectPc = linkPc + idEx.imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      exMem.valid <= 1'b0;
    end else begin
      exMem.valid <= idEx.valid;
    end
    exMem.op        <= idEx.op;
    exMem.rd        <= idEx.rd;
    exMem.regWrite  <= idEx.regWrite;
    exMem.result    <= aluOut;
    exMem.storeData <= idEx.b;
  end

  assign exMemDest = '{valid: exMem.valid, regWrite: exMem.regWrite, rd: exMem.rd};

endmodule

`default_nettype wire

//--- src/fetchInstruction.sv
// proc fetch stage: PC register, loadable instruction memory and the IF/ID register
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module fetchInstruction import proc_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              stall,
  input  wire logic              halting,
  input  wire logic              redirect,
  input  wire dataT              redirectPc,
  input  wire logic              imemWrEn,
  input  wire logic [ImemAw-1:0] imemAddr,
  input  wire dataT              imemData,
  output ifIdT                   ifId
);

  dataT              imem [`PROC_IMEM_DEPTH];
  logic [ImemAw-1:0] pc;  // Wraps with the program size
  dataT              instrWord;

  assign instrWord = imem[pc];

  // Program load port, only driven while in reset
  always_ff @(posedge clk) begin
    if (imemWrEn) imem[imemAddr] <= imemData;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc         <= '0;
      ifId.valid <= 1'b0;
    end else if (redirect) begin
      pc         <= redirectPc[ImemAw-1:0];
      ifId.valid <= 1'b0;  // Kill the wrong-path word
    end else if (halting) begin
      ifId.valid <= 1'b0;
    end else if (!stall) begin
      pc         <= pc + 1'b1;
      ifId.valid <= 1'b1;
      ifId.pc    <= dataT'(pc);
      ifId.instr <= instrWord;
    end
  end

endmodule

`default_nettype wire

//--- src/hazardDetector.sv
// proc interlock: stalls decode on read-after-write against ID/EX and EX/MEM
`timescale 1ns/1ps
`default_nettype none

module hazardDetector import proc_pkg::*; (
  input  wire srcUseT srcUse,
  input  wire destT   idExDest,
  input  wire destT   exMemDest,
  output logic        stall
);

  logic rsHit;
  logic rtHit;

  // r0 never creates a dependence
  function automatic logic hitsDest(input regIdxT src, input destT dest);
    return dest.valid && dest.regWrite && (src != '0) && (src == dest.rd);
  endfunction

  // MEM/WB is covered by register file write-through
  assign rsHit = srcUse.usesRs &&
                 (hitsDest(srcUse.rs, idExDest) || hitsDest(srcUse.rs, exMemDest));

  assign rtHit = srcUse.usesRt &&
                 (hitsDest(srcUse.rt, idExDest) || hitsDest(srcUse.rt, exMemDest));

  assign stall = rsHit || rtHit;

endmodule

`default_nettype wire

//--- src/memoryReadWrite.sv
// proc memory stage: data memory, writeback select, MEM/WB register and halted flag
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module memoryReadWrite import proc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire exMemT exMem,
  output memWbT      memWb,
  output logic       halted
);

  dataT              dmem [`PROC_DMEM_DEPTH];
  logic [DmemAw-1:0] addr;
  dataT              loadData;

  assign addr     = exMem.result[DmemAw-1:0];
  assign loadData = dmem[addr];  // Asynchronous read

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `PROC_DMEM_DEPTH; i++) dmem[i] <= '0;
    end else if (exMem.valid && exMem.op == opSt) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memWb.valid <= 1'b0;
      halted      <= 1'b0;
    end else begin
      memWb.valid <= exMem.valid;
      if (exMem.valid && exMem.op == opHalt) halted <= 1'b1;  // Sticky until reset
    end
    memWb.rd       <= exMem.rd;
    memWb.regWrite <= exMem.regWrite;
    memWb.data     <= (exMem.op == opLd) ? loadData : exMem.result;
    memWb.isHalt   <= (exMem.op == opHalt);
  end

endmodule

`default_nettype wire

//--- src/proc.sv
// proc top level: five-stage pipelined 16-bit processor with commit trace outputs
`timescale 1ns/1ps
`default_nettype none

module proc import proc_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              imemWrEn,
  input  wire logic [ImemAw-1:0] imemAddr,
  input  wire dataT              imemData,
  output logic                   wbValid,
  output regIdxT                 wbReg,
  output dataT                   wbData,
  output logic                   halted,
  output logic                   err
);

  ifIdT   ifId;
  idExT   idEx;
  exMemT  exMem;
  memWbT  memWb;
  srcUseT srcUse;
  destT   idExDest;
  destT   exMemDest;
  logic   stall;
  logic   halting;
  logic   redirect;
  dataT   redirectPc;

  fetchInstruction instructionFetch (
    .clk, .rst, .stall, .halting, .redirect, .redirectPc,
    .imemWrEn, .imemAddr, .imemData, .ifId
  );

  decodeInstruction instructionDecode (
    .clk, .rst, .ifId, .stall, .redirect, .memWb,
    .idEx, .srcUse, .idExDest, .halting, .err
  );

  hazardDetector detectHazards (.srcUse, .idExDest, .exMemDest, .stall);

  executeInstruction instructionExecute (
    .clk, .rst, .idEx, .exMem, .exMemDest, .redirect, .redirectPc
  );

  memoryReadWrite dataMemory (.clk, .rst, .exMem, .memWb, .halted);

  // Commit trace shows only real register writes
  assign wbValid = memWb.valid && memWb.regWrite && (memWb.rd != '0);
  assign wbReg   = memWb.rd;
  assign wbData  = memWb.data;

endmodule

`default_nettype wire

//--- src/proc_pkg.sv
// proc shared types: opcode encoding and the packed pipeline stage registers
`default_nettype none
`include "proc_settings.svh"

package proc_pkg;

  localparam int DataW  = `PROC_DATA_W;
  localparam int RegW   = $clog2(`PROC_NUM_REGS);
  localparam int ImemAw = $clog2(`PROC_IMEM_DEPTH);
  localparam int DmemAw = $clog2(`PROC_DMEM_DEPTH);

  typedef logic [DataW-1:0] dataT;
  typedef logic [RegW-1:0]  regIdxT;

  localparam regIdxT LinkReg = regIdxT'(`PROC_NUM_REGS - 1);  // JAL target r7

  // Codes 14 and 15 are left illegal
  typedef enum logic [3:0] {
    opNop  = 4'd0,
    opAdd  = 4'd1,
    opSub  = 4'd2,
    opAnd  = 4'd3,
    opOr   = 4'd4,
    opXor  = 4'd5,
    opAddi = 4'd6,
    opLd   = 4'd7,
    opSt   = 4'd8,
    opBeqz = 4'd9,
    opBnez = 4'd10,
    opJ    = 4'd11,
    opJal  = 4'd12,
    opHalt = `PROC_OP_HALT
  } opcodeT;

  typedef struct packed {
    logic   valid;
    dataT   pc;
    dataT   instr;
  } ifIdT;

  typedef struct packed {
    logic   valid;
    opcodeT op;
    regIdxT rd;
    logic   regWrite;
    dataT   a;      // rs value
    dataT   b;      // rt value, or rd value for ST
    dataT   imm;
    dataT   pc;
  } idExT;

  typedef struct packed {
    logic   valid;
    opcodeT op;
    regIdxT rd;
    logic   regWrite;
    dataT   result;     // ALU value, address or link
    dataT   storeData;
  } exMemT;

  typedef struct packed {
    logic   valid;
    regIdxT rd;
    logic   regWrite;
    dataT   data;       // Final writeback value
    logic   isHalt;
  } memWbT;

  // Source registers read by the instruction in IF/ID
  typedef struct packed {
    regIdxT rs;
    regIdxT rt;
    logic   usesRs;
    logic   usesRt;
  } srcUseT;

  typedef struct packed {
    logic   valid;
    logic   regWrite;
    regIdxT rd;
  } destT;

endpackage

`default_nettype wire
